/* logic/zynq_shell_settings.svh */
`ifndef ZYNQ_SHELL_SETTINGS_SVH
`define ZYNQ_SHELL_SETTINGS_SVH

// bus and register widths
`define ZS_ADDR_W      32
`define ZS_DATA_W      32
`define ZS_CSR_ADDR_W  6

// DRAM starts here in the device physical map
`define ZS_DRAM_BASE   32'h8000_0000
// 120 MB above the DRAM base
`define ZS_MEM_LIMIT   32'h0780_0000

`define ZS_REGIONS     128
`define ZS_CNT_W       16

// register byte offsets
`define ZS_REG_CTRL    6'h00
`define ZS_REG_BASE    6'h04
`define ZS_REG_HIGH    6'h08
// the four profiler words follow this one with a stride of 4 bytes
`define ZS_REG_PROF0   6'h10

`endif

/* logic/zynq_shell_pkg.sv */
`default_nettype none

`include "zynq_shell_settings.svh"

package zynq_shell_pkg;

   // one bit per 8 MB region in the profiler map
   typedef logic [6:0] region_t;

   // device address as seen by the profiler
   typedef struct packed {
      logic [1:0]  space;
      region_t     region;
      logic [22:0] offset;
   } dev_addr_fields_t;

   // the remap works on the raw word and the profiler on the fields
   typedef union packed {
      logic [`ZS_ADDR_W-1:0] raw;
      dev_addr_fields_t      fields;
   } dev_addr_u;

endpackage

`default_nettype wire

/* logic/mem_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_settings.svh"

// a remapped DRAM request with the device region it came from
interface mem_req_if;

   logic                    valid;
   logic                    ready;
   logic [`ZS_ADDR_W-1:0]   addr;
   logic                    write;
   zynq_shell_pkg::region_t region;

   modport src
   (
      output valid
      , output addr
      , output write
      , output region
      , input  ready
   );

   // the profiler only watches the handshake
   modport mon
   (
      input valid
      , input ready
      , input addr
      , input write
      , input region
   );

endinterface

`default_nettype wire

/* logic/dram_remap.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_settings.svh"

module dram_remap
(
   input  logic                      aclk
   , input  logic                    arst_n_i
   , input  logic                    req_valid_i
   , input  logic                    req_write_i
   , input  zynq_shell_pkg::dev_addr_u req_addr_i
   , output logic                    req_ready_o
   , input  logic [`ZS_ADDR_W-1:0]   dram_base_i
   , output logic [`ZS_CNT_W-1:0]    high_count_o
   , mem_req_if.src                  out
);

   logic                  accept;
   logic                  is_high;
   logic [`ZS_ADDR_W-1:0] dram_offset;
   logic [`ZS_ADDR_W-1:0] host_addr;

   // take a new request when the stage is empty or drains this cycle
   assign req_ready_o = ~out.valid | out.ready;
   assign accept      = req_valid_i & req_ready_o;

   // flipping bit 31 turns the device DRAM address into an offset from its base
   assign dram_offset = req_addr_i.raw ^ `ZS_DRAM_BASE;
   assign host_addr   = dram_offset + dram_base_i;
   assign is_high     = dram_offset >= `ZS_MEM_LIMIT;

   always_ff @(posedge aclk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         out.valid <= 1'b0;
      end
      else if (accept)
      begin
         out.valid <= 1'b1;
      end
      else if (out.ready)
      begin
         out.valid <= 1'b0;
      end
   end

   // payload only loads on acceptance so it holds under back-pressure
   always_ff @(posedge aclk)
   begin
      if (accept)
      begin
         out.addr   <= host_addr;
         out.write  <= req_write_i;
         out.region <= req_addr_i.fields.region;
      end
   end

   // saturating count of accepted requests beyond the memory limit
   always_ff @(posedge aclk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         high_count_o <= '0;
      end
      else if (accept && is_high && (high_count_o != {`ZS_CNT_W{1'b1}}))
      begin
         high_count_o <= high_count_o + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* logic/mem_profiler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_settings.svh"

module mem_profiler
(
   input  logic                    aclk
   , input  logic                  arst_n_i
   , input  logic                  dev_run_i
   , mem_req_if.mon                req
   , output logic [`ZS_REGIONS-1:0] prof_map_o
);

   logic                    fire;
   zynq_shell_pkg::region_t hit_idx;
   logic [`ZS_REGIONS-1:0]  hit_vec;

   assign fire    = req.valid & req.ready;
   assign hit_idx = req.region;

   // one-hot mark for the region being forwarded this cycle
   assign hit_vec = fire ? ({{(`ZS_REGIONS-1){1'b0}}, 1'b1} << hit_idx) : '0;

   // the map is held clear while the device sits in reset
   // so every rerun starts with an empty profile
   always_ff @(posedge aclk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         prof_map_o <= '0;
      end
      else if (!dev_run_i)
      begin
         prof_map_o <= '0;
      end
      else
      begin
         prof_map_o <= prof_map_o | hit_vec;
      end
   end

endmodule

`default_nettype wire

/* logic/csr_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_settings.svh"

module csr_regs
(
   input  logic                         aclk
   , input  logic                       arst_n_i
   , input  logic [`ZS_CSR_ADDR_W-1:0]  s_axil_awaddr_i
   , input  logic                       s_axil_awvalid_i
   , output logic                       s_axil_awready_o
   , input  logic [`ZS_DATA_W-1:0]      s_axil_wdata_i
   , input  logic [`ZS_DATA_W/8-1:0]    s_axil_wstrb_i
   , input  logic                       s_axil_wvalid_i
   , output logic                       s_axil_wready_o
   , output logic [1:0]                 s_axil_bresp_o
   , output logic                       s_axil_bvalid_o
   , input  logic                       s_axil_bready_i
   , input  logic [`ZS_CSR_ADDR_W-1:0]  s_axil_araddr_i
   , input  logic                       s_axil_arvalid_i
   , output logic                       s_axil_arready_o
   , output logic [`ZS_DATA_W-1:0]      s_axil_rdata_o
   , output logic [1:0]                 s_axil_rresp_o
   , output logic                       s_axil_rvalid_o
   , input  logic                       s_axil_rready_i
   , output logic                       dev_run_o
   , output logic [`ZS_ADDR_W-1:0]      dram_base_o
   , input  logic [`ZS_CNT_W-1:0]       high_count_i
   , input  logic [`ZS_REGIONS-1:0]     prof_map_i
);

   logic                      wr_fire;
   logic                      rd_fire;
   logic [`ZS_CSR_ADDR_W-1:0] wr_off;
   logic [`ZS_CSR_ADDR_W-1:0] rd_off;
   logic [`ZS_DATA_W-1:0]     rd_mux;
   logic                      ctrl_run_q;
   logic [`ZS_ADDR_W-1:0]     dram_base_q;

   // address and data are taken together, once the last response is gone
   assign s_axil_awready_o = s_axil_awvalid_i & s_axil_wvalid_i & ~s_axil_bvalid_o;
   assign s_axil_wready_o  = s_axil_awready_o;
   assign wr_fire          = s_axil_awready_o;
   assign s_axil_bresp_o   = 2'b00;

   assign s_axil_arready_o = ~s_axil_rvalid_o;
   assign rd_fire          = s_axil_arvalid_i & s_axil_arready_o;
   assign s_axil_rresp_o   = 2'b00;

   // registers are word aligned so the low address bits are ignored
   assign wr_off = {s_axil_awaddr_i[`ZS_CSR_ADDR_W-1:2], 2'b00};
   assign rd_off = {s_axil_araddr_i[`ZS_CSR_ADDR_W-1:2], 2'b00};

   assign dev_run_o   = ctrl_run_q;
   assign dram_base_o = dram_base_q;

   always_ff @(posedge aclk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ctrl_run_q  <= 1'b0;
         dram_base_q <= '0;
      end
      else if (wr_fire)
      begin
         if (wr_off == `ZS_REG_CTRL && s_axil_wstrb_i[0])
         begin
            ctrl_run_q <= s_axil_wdata_i[0];
         end
         if (wr_off == `ZS_REG_BASE)
         begin
            for (int i = 0; i < `ZS_DATA_W/8; i++)
            begin
               if (s_axil_wstrb_i[i])
               begin
                  dram_base_q[8*i +: 8] <= s_axil_wdata_i[8*i +: 8];
               end
            end
         end
      end
   end

   always_ff @(posedge aclk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         s_axil_bvalid_o <= 1'b0;
      end
      else if (wr_fire)
      begin
         s_axil_bvalid_o <= 1'b1;
      end
      else if (s_axil_bready_i)
      begin
         s_axil_bvalid_o <= 1'b0;
      end
   end

   // unmapped offsets read back as zero
   always_comb
   begin
      rd_mux = '0;
      case (rd_off)
         `ZS_REG_CTRL: rd_mux = {{(`ZS_DATA_W-1){1'b0}}, ctrl_run_q};
         `ZS_REG_BASE: rd_mux = dram_base_q;
         `ZS_REG_HIGH: rd_mux = {{(`ZS_DATA_W-`ZS_CNT_W){1'b0}}, high_count_i};
         `ZS_REG_PROF0:             rd_mux = prof_map_i[31:0];
         (`ZS_REG_PROF0 + 6'h04):   rd_mux = prof_map_i[63:32];
         (`ZS_REG_PROF0 + 6'h08):   rd_mux = prof_map_i[95:64];
         (`ZS_REG_PROF0 + 6'h0C):   rd_mux = prof_map_i[127:96];
         default:                   rd_mux = '0;
      endcase
   end

   always_ff @(posedge aclk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         s_axil_rvalid_o <= 1'b0;
      end
      else if (rd_fire)
      begin
         s_axil_rvalid_o <= 1'b1;
      end
      else if (s_axil_rready_i)
      begin
         s_axil_rvalid_o <= 1'b0;
      end
   end

   // read data is captured with the address and held until rready
   always_ff @(posedge aclk)
   begin
      if (rd_fire)
      begin
         s_axil_rdata_o <= rd_mux;
      end
   end

endmodule

`default_nettype wire

/* logic/zynq_shell_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_settings.svh"

module zynq_shell_top
(
   input  logic                         aclk
   , input  logic                       arst_n_i
   , input  logic [`ZS_CSR_ADDR_W-1:0]  s_axil_awaddr_i
   , input  logic                       s_axil_awvalid_i
   , output logic                       s_axil_awready_o
   , input  logic [`ZS_DATA_W-1:0]      s_axil_wdata_i
   , input  logic [`ZS_DATA_W/8-1:0]    s_axil_wstrb_i
   , input  logic                       s_axil_wvalid_i
   , output logic                       s_axil_wready_o
   , output logic [1:0]                 s_axil_bresp_o
   , output logic                       s_axil_bvalid_o
   , input  logic                       s_axil_bready_i
   , input  logic [`ZS_CSR_ADDR_W-1:0]  s_axil_araddr_i
   , input  logic                       s_axil_arvalid_i
   , output logic                       s_axil_arready_o
   , output logic [`ZS_DATA_W-1:0]      s_axil_rdata_o
   , output logic [1:0]                 s_axil_rresp_o
   , output logic                       s_axil_rvalid_o
   , input  logic                       s_axil_rready_i
   , input  logic                       dev_req_valid_i
   , output logic                       dev_req_ready_o
   , input  logic [`ZS_ADDR_W-1:0]      dev_req_addr_i
   , input  logic                       dev_req_write_i
   , output logic                       dram_req_valid_o
   , input  logic                       dram_req_ready_i
   , output logic [`ZS_ADDR_W-1:0]      dram_req_addr_o
   , output logic                       dram_req_write_o
   , output logic                       dev_reset_o
);

   logic                   dev_run;
   logic [`ZS_ADDR_W-1:0]  dram_base;
   logic [`ZS_CNT_W-1:0]   high_count;
   logic [`ZS_REGIONS-1:0] prof_map;

   mem_req_if dram_req ();

   assign dram_req.ready   = dram_req_ready_i;
   assign dram_req_valid_o = dram_req.valid;
   assign dram_req_addr_o  = dram_req.addr;
   assign dram_req_write_o = dram_req.write;

   // the device stays in reset until the host sets the run bit
   assign dev_reset_o = ~dev_run;

   csr_regs u_csr
   (
      .aclk                (aclk)
      , .arst_n_i          (arst_n_i)
      , .s_axil_awaddr_i   (s_axil_awaddr_i)
      , .s_axil_awvalid_i  (s_axil_awvalid_i)
      , .s_axil_awready_o  (s_axil_awready_o)
      , .s_axil_wdata_i    (s_axil_wdata_i)
      , .s_axil_wstrb_i    (s_axil_wstrb_i)
      , .s_axil_wvalid_i   (s_axil_wvalid_i)
      , .s_axil_wready_o   (s_axil_wready_o)
      , .s_axil_bresp_o    (s_axil_bresp_o)
      , .s_axil_bvalid_o   (s_axil_bvalid_o)
      , .s_axil_bready_i   (s_axil_bready_i)
      , .s_axil_araddr_i   (s_axil_araddr_i)
      , .s_axil_arvalid_i  (s_axil_arvalid_i)
      , .s_axil_arready_o  (s_axil_arready_o)
      , .s_axil_rdata_o    (s_axil_rdata_o)
      , .s_axil_rresp_o    (s_axil_rresp_o)
      , .s_axil_rvalid_o   (s_axil_rvalid_o)
      , .s_axil_rready_i   (s_axil_rready_i)
      , .dev_run_o         (dev_run)
      , .dram_base_o       (dram_base)
      , .high_count_i      (high_count)
      , .prof_map_i        (prof_map)
   );

   dram_remap u_remap
   (
      .aclk           (aclk)
      , .arst_n_i     (arst_n_i)
      , .req_valid_i  (dev_req_valid_i)
      , .req_write_i  (dev_req_write_i)
      , .req_addr_i   (dev_req_addr_i)
      , .req_ready_o  (dev_req_ready_o)
      , .dram_base_i  (dram_base)
      , .high_count_o (high_count)
      , .out          (dram_req.src)
   );

   mem_profiler u_prof
   (
      .aclk         (aclk)
      , .arst_n_i   (arst_n_i)
      , .dev_run_i  (dev_run)
      , .req        (dram_req.mon)
      , .prof_map_o (prof_map)
   );

endmodule

`default_nettype wire

/* bench/zynq_shell_props.sv */
`timescale 1ns/1ps
`default_nettype none

module zynq_shell_props
(
   input  logic        aclk
   , input  logic      arst_n_i
   , input  logic      dram_req_valid_o
   , input  logic      dram_req_ready_i
   , input  logic [31:0] dram_req_addr_o
   , input  logic      dram_req_write_o
   , input  logic [5:0] s_axil_awaddr_i
   , input  logic      s_axil_awvalid_i
   , input  logic      s_axil_awready_o
   , input  logic [31:0] s_axil_wdata_i
   , input  logic [3:0] s_axil_wstrb_i
   , input  logic      s_axil_wvalid_i
   , input  logic      s_axil_wready_o
   , input  logic      s_axil_bvalid_o
   , input  logic      s_axil_bready_i
   , input  logic      s_axil_rvalid_o
   , input  logic      s_axil_rready_i
   , input  logic [31:0] s_axil_rdata_o
   , input  logic      dev_reset_o
);

   int unsigned assert_fail_cnt = 0;
   logic        ctrl_wr;

   // a host write that reaches bit 0 of the control register
   assign ctrl_wr = s_axil_awvalid_i && s_axil_awready_o && s_axil_wvalid_i
                    && s_axil_wready_o && (s_axil_awaddr_i[5:2] == 4'h0) && s_axil_wstrb_i[0];

   // a stalled DRAM request must not move or change
   dram_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
      dram_req_valid_o && !dram_req_ready_i |=>
      dram_req_valid_o && $stable(dram_req_addr_o) && $stable(dram_req_write_o))
   else
   begin
      $error("DRAM request changed while stalled");
      assert_fail_cnt++;
   end

   bvalid_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
      s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o)
   else
   begin
      $error("write response dropped before bready");
      assert_fail_cnt++;
   end

   rvalid_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
      s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_rdata_o))
   else
   begin
      $error("read response dropped or changed before rready");
      assert_fail_cnt++;
   end

   // the run bit written by the host shows on the device reset one cycle later
   run_reset: assert property (@(posedge aclk) disable iff (!arst_n_i)
      ctrl_wr |=> dev_reset_o == !$past(s_axil_wdata_i[0]))
   else
   begin
      $error("device reset does not follow the written run bit");
      assert_fail_cnt++;
   end

   // without a control write the device reset keeps its level
   reset_steady: assert property (@(posedge aclk) disable iff (!arst_n_i)
      !ctrl_wr |=> $stable(dev_reset_o))
   else
   begin
      $error("device reset changed without a control write");
      assert_fail_cnt++;
   end

   // nothing may be offered while the shell itself is in reset
   quiet_in_reset: assert property (@(posedge aclk)
      !arst_n_i |-> !dram_req_valid_o && !s_axil_bvalid_o && !s_axil_rvalid_o)
   else
   begin
      $error("output valid set during reset");
      assert_fail_cnt++;
   end

endmodule

`default_nettype wire

/* bench/zynq_shell_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_settings.svh"

module zynq_shell_tb;

   localparam int op_wr  = 0;
   localparam int op_rd  = 1;
   localparam int op_chk = 2;
   localparam int op_req = 3;
   localparam int op_rst = 4;

   // op_rd compares with exp, op_chk with the model, op_req carries the write flag in data
   typedef struct {
      int          kind;
      string       name;
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  strb;
      logic [31:0] exp;
   } step_t;

   logic aclk;
   logic arst_n_i;
   logic [`ZS_CSR_ADDR_W-1:0] s_axil_awaddr_i;
   logic s_axil_awvalid_i;
   logic s_axil_awready_o;
   logic [`ZS_DATA_W-1:0] s_axil_wdata_i;
   logic [`ZS_DATA_W/8-1:0] s_axil_wstrb_i;
   logic s_axil_wvalid_i;
   logic s_axil_wready_o;
   logic [1:0] s_axil_bresp_o;
   logic s_axil_bvalid_o;
   logic s_axil_bready_i;
   logic [`ZS_CSR_ADDR_W-1:0] s_axil_araddr_i;
   logic s_axil_arvalid_i;
   logic s_axil_arready_o;
   logic [`ZS_DATA_W-1:0] s_axil_rdata_o;
   logic [1:0] s_axil_rresp_o;
   logic s_axil_rvalid_o;
   logic s_axil_rready_i;
   logic dev_req_valid_i;
   logic dev_req_ready_o;
   logic [`ZS_ADDR_W-1:0] dev_req_addr_i;
   logic dev_req_write_i;
   logic dram_req_valid_o;
   logic dram_req_ready_i;
   logic [`ZS_ADDR_W-1:0] dram_req_addr_o;
   logic dram_req_write_o;
   logic dev_reset_o;

   step_t       steps[$];
   logic [31:0] exp_addr_q[$];
   logic        exp_write_q[$];
   string       exp_name_q[$];
   logic [31:0] lcg_state;
   int          pass_cnt;
   int          fail_cnt;
   int          cycle_cnt;
   int          cycle_limit;
   logic [1:0]  resp;
   logic [31:0] rdata;
   logic [31:0] exp_val;
   string       mon_name;
   logic [31:0] mon_addr;
   logic        mon_write;

   // reference state of the shell
   logic                   m_run;
   logic [31:0]            m_base;
   logic [`ZS_CNT_W-1:0]   m_high;
   logic [`ZS_REGIONS-1:0] m_map;

   zynq_shell_top UUT (.*);

   bind zynq_shell_top zynq_shell_props u_props
   (
      .aclk               (aclk)
      , .arst_n_i         (arst_n_i)
      , .dram_req_valid_o (dram_req_valid_o)
      , .dram_req_ready_i (dram_req_ready_i)
      , .dram_req_addr_o  (dram_req_addr_o)
      , .dram_req_write_o (dram_req_write_o)
      , .s_axil_awaddr_i  (s_axil_awaddr_i)
      , .s_axil_awvalid_i (s_axil_awvalid_i)
      , .s_axil_awready_o (s_axil_awready_o)
      , .s_axil_wdata_i   (s_axil_wdata_i)
      , .s_axil_wstrb_i   (s_axil_wstrb_i)
      , .s_axil_wvalid_i  (s_axil_wvalid_i)
      , .s_axil_wready_o  (s_axil_wready_o)
      , .s_axil_bvalid_o  (s_axil_bvalid_o)
      , .s_axil_bready_i  (s_axil_bready_i)
      , .s_axil_rvalid_o  (s_axil_rvalid_o)
      , .s_axil_rready_i  (s_axil_rready_i)
      , .s_axil_rdata_o   (s_axil_rdata_o)
      , .dev_reset_o      (dev_reset_o)
   );

   always #20 aclk = ~aclk;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] model_reg(input logic [5:0] off);
      if (off >= `ZS_REG_PROF0 && off < `ZS_REG_PROF0 + 6'h10)
      begin
         return m_map[32*((off - `ZS_REG_PROF0) / 4) +: 32];
      end
      case (off)
         `ZS_REG_CTRL: return {31'b0, m_run};
         `ZS_REG_BASE: return m_base;
         `ZS_REG_HIGH: return {{(32-`ZS_CNT_W){1'b0}}, m_high};
         default:      return 32'h0;
      endcase
   endfunction

   task automatic note_pass(input string name);
      $display("PASS %s", name);
      pass_cnt++;
   endtask

   task automatic report_mismatch(input string name, input logic [32:0] exp,
                                  input logic [32:0] act);
      $display("FAIL %s expected %h actual %h", name, exp, act);
      fail_cnt++;
   endtask

   // a read must answer OKAY before its data counts
   task automatic check_read(input string name, input logic [31:0] exp,
                             input logic [31:0] data, input logic [1:0] rresp);
      if (rresp !== 2'b00)
      begin
         report_mismatch(name, 0, rresp);
      end
      else if (data !== exp)
      begin
         report_mismatch(name, exp, data);
      end
      else
      begin
         note_pass(name);
      end
   endtask

   task automatic add_step(input int kind, input string name, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input logic [31:0] exp);
      step_t s;
      s.kind = kind;
      s.name = name;
      s.addr = addr;
      s.data = data;
      s.strb = strb;
      s.exp  = exp;
      steps.push_back(s);
   endtask

   task automatic build_table();
      logic [31:0] r;
      add_step(op_rd, "reset_ctrl", `ZS_REG_CTRL, 0, 0, 0);
      add_step(op_rd, "reset_base", `ZS_REG_BASE, 0, 0, 0);
      add_step(op_rd, "reset_high", `ZS_REG_HIGH, 0, 0, 0);
      for (int i = 0; i < 4; i++)
      begin
         add_step(op_rd, $sformatf("reset_prof%0d", i), `ZS_REG_PROF0 + 4*i, 0, 0, 0);
      end
      add_step(op_rst, "reset_dev_reset", 0, 0, 0, 1);
      add_step(op_wr, "base_write_full", `ZS_REG_BASE, 32'h1234_5678, 4'hF, 0);
      add_step(op_rd, "base_read_full", `ZS_REG_BASE, 0, 0, 32'h1234_5678);
      add_step(op_wr, "base_write_strb", `ZS_REG_BASE, 32'hAABB_CCDD, 4'b0101, 0);
      add_step(op_rd, "base_read_strb", `ZS_REG_BASE, 0, 0, 32'h12BB_56DD);
      add_step(op_wr, "run_on", `ZS_REG_CTRL, 1, 4'hF, 0);
      add_step(op_rst, "run_on_dev_reset", 0, 0, 0, 0);
      add_step(op_wr, "high_write", `ZS_REG_HIGH, 32'hFFFF_FFFF, 4'hF, 0);
      add_step(op_rd, "high_read_only", `ZS_REG_HIGH, 0, 0, 0);
      add_step(op_rd, "unmapped_0c", 6'h0C, 0, 0, 0);
      add_step(op_rd, "unmapped_20", 6'h20, 0, 0, 0);
      // both sides of the 120 MB limit and the top region
      add_step(op_req, "req_dram_base", 32'h8000_0000, 0, 0, 0);
      add_step(op_req, "req_below_limit", 32'h877F_FFFF, 1, 0, 0);
      add_step(op_req, "req_at_limit", 32'h8780_0000, 0, 0, 0);
      add_step(op_req, "req_top_region", 32'hBFFF_FFFC, 1, 0, 0);
      for (int i = 0; i < 16; i++)
      begin
         lcg_state = lcg_step(lcg_state);
         r = lcg_state;
         if (r[31])
         begin
            r = 32'h8000_0000 | (r & 32'h0FFF_FFFF);
         end
         else
         begin
            r = 32'h8000_0000 | (r & 32'h3FFF_FFFF);
         end
         add_step(op_req, $sformatf("req_rand%0d", i), r, {31'b0, lcg_state[20]}, 0, 0);
      end
      add_step(op_chk, "high_count", `ZS_REG_HIGH, 0, 0, 0);
      for (int i = 0; i < 4; i++)
      begin
         add_step(op_chk, $sformatf("prof%0d", i), `ZS_REG_PROF0 + 4*i, 0, 0, 0);
      end
      add_step(op_wr, "run_off", `ZS_REG_CTRL, 0, 4'hF, 0);
      add_step(op_rst, "run_off_dev_reset", 0, 0, 0, 1);
      add_step(op_wr, "run_again", `ZS_REG_CTRL, 1, 4'hF, 0);
      for (int i = 0; i < 4; i++)
      begin
         add_step(op_chk, $sformatf("rerun_prof%0d", i), `ZS_REG_PROF0 + 4*i, 0, 0, 0);
      end
      add_step(op_chk, "rerun_high_kept", `ZS_REG_HIGH, 0, 0, 0);
   endtask

   task automatic model_write(input logic [5:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
      if (addr == `ZS_REG_CTRL && strb[0])
      begin
         m_run = data[0];
         if (!m_run)
         begin
            m_map = '0;
         end
      end
      if (addr == `ZS_REG_BASE)
      begin
         for (int b = 0; b < 4; b++)
         begin
            if (strb[b])
            begin
               m_base[8*b +: 8] = data[8*b +: 8];
            end
         end
      end
   endtask

   task automatic model_request(input string name, input logic [31:0] addr, input logic wr);
      zynq_shell_pkg::dev_addr_u dev;
      logic [31:0] offset;
      dev.raw = addr;
      offset  = addr ^ `ZS_DRAM_BASE;
      exp_addr_q.push_back(offset + m_base);
      exp_write_q.push_back(wr);
      exp_name_q.push_back(name);
      if (offset >= `ZS_MEM_LIMIT && m_high != {`ZS_CNT_W{1'b1}})
      begin
         m_high = m_high + 1'b1;
      end
      if (m_run)
      begin
         m_map[dev.fields.region] = 1'b1;
      end
   endtask

   // the response is left waiting one cycle before it is taken
   task automatic write_register(input logic [5:0] addr, input logic [31:0] data,
                                 input logic [3:0] strb, output logic [1:0] bresp);
      @(negedge aclk);
      s_axil_awaddr_i  = addr;
      s_axil_wdata_i   = data;
      s_axil_wstrb_i   = strb;
      s_axil_awvalid_i = 1'b1;
      s_axil_wvalid_i  = 1'b1;
      // address and data are taken together once both readies are up
      #10;
      while (!(s_axil_awready_o && s_axil_wready_o))
      begin
         @(negedge aclk);
         #10;
      end
      @(negedge aclk);
      s_axil_awvalid_i = 1'b0;
      s_axil_wvalid_i  = 1'b0;
      while (!s_axil_bvalid_o)
      begin
         @(negedge aclk);
      end
      @(negedge aclk);
      bresp           = s_axil_bresp_o;
      s_axil_bready_i = 1'b1;
      @(negedge aclk);
      s_axil_bready_i = 1'b0;
   endtask

   task automatic read_register(input logic [5:0] addr, output logic [31:0] data,
                                output logic [1:0] rresp);
      @(negedge aclk);
      s_axil_araddr_i  = addr;
      s_axil_arvalid_i = 1'b1;
      #10;
      while (!s_axil_arready_o)
      begin
         @(negedge aclk);
         #10;
      end
      @(negedge aclk);
      s_axil_arvalid_i = 1'b0;
      while (!s_axil_rvalid_o)
      begin
         @(negedge aclk);
      end
      @(negedge aclk);
      data            = s_axil_rdata_o;
      rresp           = s_axil_rresp_o;
      s_axil_rready_i = 1'b1;
      @(negedge aclk);
      s_axil_rready_i = 1'b0;
   endtask

   task automatic send_request(input string name, input logic [31:0] addr, input logic wr);
      logic taken;
      taken = 1'b0;
      @(negedge aclk);
      dev_req_valid_i = 1'b1;
      dev_req_addr_i  = addr;
      dev_req_write_i = wr;
      while (!taken)
      begin
         // ready follows the DRAM side, so look a quarter period after the edge
         #10;
         taken = dev_req_ready_o;
         if (taken)
         begin
            model_request(name, addr, wr);
         end
         @(negedge aclk);
      end
      dev_req_valid_i = 1'b0;
   endtask

   // random back-pressure on the DRAM port and in-order check of what leaves it
   always @(negedge aclk)
   begin
      lcg_state        = lcg_step(lcg_state);
      dram_req_ready_i = (lcg_state[17:16] != 2'b00);
      if (dram_req_valid_o && dram_req_ready_i)
      begin
         if (exp_addr_q.size() == 0)
         begin
            $display("error: DRAM request to %h appeared with none pending", dram_req_addr_o);
            fail_cnt++;
         end
         else
         begin
            mon_name  = exp_name_q.pop_front();
            mon_addr  = exp_addr_q.pop_front();
            mon_write = exp_write_q.pop_front();
            if ({dram_req_write_o, dram_req_addr_o} !== {mon_write, mon_addr})
            begin
               report_mismatch(mon_name, {mon_write, mon_addr},
                               {dram_req_write_o, dram_req_addr_o});
            end
            else
            begin
               note_pass(mon_name);
            end
         end
      end
   end

   initial
   begin
      cycle_cnt = 0;
      wait (cycle_limit != 0);
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge aclk);
         cycle_cnt++;
      end
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      aclk             = 1'b0;
      arst_n_i         = 1'b0;
      s_axil_awaddr_i  = '0;
      s_axil_awvalid_i = 1'b0;
      s_axil_wdata_i   = '0;
      s_axil_wstrb_i   = '0;
      s_axil_wvalid_i  = 1'b0;
      s_axil_bready_i  = 1'b0;
      s_axil_araddr_i  = '0;
      s_axil_arvalid_i = 1'b0;
      s_axil_rready_i  = 1'b0;
      dev_req_valid_i  = 1'b0;
      dev_req_addr_i   = '0;
      dev_req_write_i  = 1'b0;
      dram_req_ready_i = 1'b0;
      pass_cnt         = 0;
      fail_cnt         = 0;
      m_run            = 1'b0;
      m_base           = '0;
      m_high           = '0;
      m_map            = '0;
      lcg_state        = 32'hed533e7a;
      build_table();
      cycle_limit = steps.size() * 40 + 100;
      repeat (10) @(posedge aclk);
      @(negedge aclk);
      arst_n_i = 1'b1;
      if (dram_req_valid_o !== 1'b0)
      begin
         report_mismatch("reset_dram_valid", 0, dram_req_valid_o);
      end
      else
      begin
         note_pass("reset_dram_valid");
      end
      foreach (steps[i])
      begin
         case (steps[i].kind)
            op_wr:
            begin
               write_register(steps[i].addr[5:0], steps[i].data, steps[i].strb, resp);
               model_write(steps[i].addr[5:0], steps[i].data, steps[i].strb);
               if (resp !== 2'b00)
               begin
                  report_mismatch(steps[i].name, 0, resp);
               end
               else
               begin
                  note_pass(steps[i].name);
               end
            end
            op_rd:
            begin
               read_register(steps[i].addr[5:0], rdata, resp);
               check_read(steps[i].name, steps[i].exp, rdata, resp);
            end
            op_chk:
            begin
               // let every pending request reach DRAM and mark the profiler first
               while (exp_addr_q.size() != 0)
               begin
                  @(negedge aclk);
               end
               @(negedge aclk);
               read_register(steps[i].addr[5:0], rdata, resp);
               exp_val = model_reg(steps[i].addr[5:0]);
               check_read(steps[i].name, exp_val, rdata, resp);
            end
            op_req:
            begin
               send_request(steps[i].name, steps[i].addr, steps[i].data[0]);
            end
            default:
            begin
               @(negedge aclk);
               if (dev_reset_o !== steps[i].exp[0])
               begin
                  report_mismatch(steps[i].name, steps[i].exp[0], dev_reset_o);
               end
               else
               begin
                  note_pass(steps[i].name);
               end
            end
         endcase
      end
      while (exp_addr_q.size() != 0)
      begin
         @(negedge aclk);
      end
      if (UUT.u_props.assert_fail_cnt != 0)
      begin
         $display("error: %0d assertion failures", UUT.u_props.assert_fail_cnt);
         fail_cnt += UUT.u_props.assert_fail_cnt;
      end
      $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+logic
logic/zynq_shell_pkg.sv
logic/mem_req_if.sv
logic/dram_remap.sv
logic/mem_profiler.sv
logic/csr_regs.sv
logic/zynq_shell_top.sv
bench/zynq_shell_props.sv
bench/zynq_shell_tb.sv
